//--- common/ex_pkg.sv
`default_nettype none

package ex_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data path and register file widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN      = 32;  // Integer data path
  localparam int unsigned RF_ADDR_W = 6;   // GPR bank plus FP bank
  localparam int unsigned SHAMT_W   = 5;   // Shift amount bits of operand B

  typedef logic [XLEN-1:0]      data_t;
  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  //////////////////////////////////////////////////////////////////////
  // ALU operations
  //////////////////////////////////////////////////////////////////////

  // Arithmetic, logic and shifts first, branch compares last
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,   // Signed set-less-than
    ALU_SLTU = 4'd9,   // Unsigned set-less-than
    ALU_EQ   = 4'd10,  // Branch compares
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////
  // Multiplier operations and sequencer
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    MUL_LO = 2'd0,  // Low word of product
    MUL_HS = 2'd1,  // High word signed x signed
    MUL_HU = 2'd2   // High word unsigned x unsigned
  } mult_op_e;

  // High-word sequencer
  typedef enum logic [1:0] {
    MULT_IDLE  = 2'd0,
    MULT_STEP1 = 2'd1,  // Upper partial product being added
    MULT_DONE  = 2'd2   // High word ready, wait for EX to accept
  } mult_state_e;

  // Cycles a MUL_HS or MUL_HU occupies the stage
  localparam int unsigned MULT_HI_CYCLES = 3;

endpackage

`default_nettype wire

//--- common/ex_mult_if.sv
`timescale 1ns/1ps
`default_nettype none

// Stage control <-> multiplier
interface ex_mult_if;
  import ex_pkg::*;

  logic       en;          // Multiply op present in EX
  mult_op_e   op;
  data_t      op_a;
  data_t      op_b;
  data_t      result;
  logic       ready;       // Low while result not yet final
  logic       multicycle;  // High-word op still busy
  logic       ex_ready;    // EX accepts, multiplier may retire

  modport unit (
    input  en, op, op_a, op_b, ex_ready,
    output result, ready, multicycle
  );

  modport ctrl (
    input  en, result, ready,
    output ex_ready
  );

endinterface

`default_nettype wire

//--- rtl/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::data_t   operand_a_i,
  input  ex_pkg::data_t   operand_b_i,
  output ex_pkg::data_t   result_o,
  output logic            cmp_result_o  // Branch decision
);
  import ex_pkg::*;

  logic [SHAMT_W-1:0] shamt;
  logic [XLEN:0]      diff;         // One subtractor serves SUB and all compares
  logic               lt_unsigned;
  logic               lt_signed;
  logic               is_equal;
  data_t              shift_left;
  logic [XLEN:0]      shift_in;     // Extra MSB carries sign for SRA
  logic [XLEN:0]      shift_right;

  //////////////////////////////////////////////////////////////////////
  // Shared subtractor and compare flags
  //////////////////////////////////////////////////////////////////////

  assign diff        = {1'b0, operand_a_i} - {1'b0, operand_b_i};
  assign lt_unsigned = diff[XLEN];  // Borrow out
  assign is_equal    = (diff[XLEN-1:0] == '0);

  // Different signs decide directly, same signs fall back to borrow
  assign lt_signed = (operand_a_i[XLEN-1] != operand_b_i[XLEN-1]) ?
                     operand_a_i[XLEN-1] : lt_unsigned;

  //////////////////////////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////////////////////////

  assign shamt      = operand_b_i[SHAMT_W-1:0];
  assign shift_left = operand_a_i << shamt;

  // SRL and SRA share one arithmetic right shift
  assign shift_in    = {(operator_i == ALU_SRA) & operand_a_i[XLEN-1], operand_a_i};
  assign shift_right = $unsigned($signed(shift_in) >>> shamt);

  // Branch compares
  always_comb begin
    case (operator_i)
      ALU_EQ:  cmp_result_o = is_equal;
      ALU_NE:  cmp_result_o = ~is_equal;
      ALU_LT:  cmp_result_o = lt_signed;
      ALU_GE:  cmp_result_o = ~lt_signed;
      ALU_LTU: cmp_result_o = lt_unsigned;
      ALU_GEU: cmp_result_o = ~lt_unsigned;
      default: cmp_result_o = 1'b0;  // Not a branch
    endcase
  end

  // Result select
  always_comb begin
    case (operator_i)
      ALU_ADD:  result_o = operand_a_i + operand_b_i;
      ALU_SUB:  result_o = diff[XLEN-1:0];
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:  result_o = shift_left;
      ALU_SRL,
      ALU_SRA:  result_o = shift_right[XLEN-1:0];
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      // Compare ops also return their flag as 0 or 1
      default:  result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

`default_nettype wire

//--- mult/ex_mult.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mult (
  input  logic    clk,
  input  logic    rst_n,
  ex_mult_if.unit m_if
);
  import ex_pkg::*;

  mult_state_e                   state_q;
  mult_state_e                   state_d;
  logic                          hi_op;     // MUL_HS or MUL_HU
  logic                          hi_start;  // First cycle of a high op
  logic                          op_signed;
  logic signed [XLEN:0]          op_a_ext;  // 33 bits cover both signed and unsigned
  logic signed [XLEN:0]          op_b_ext;
  logic signed [XLEN/2:0]        pp_b;      // Selected 17-bit slice of B
  logic signed [XLEN+XLEN/2+1:0] pp;        // 33 x 17 partial product
  logic [2*XLEN-1:0]             pp_ext;
  logic [2*XLEN-1:0]             acc_q;     // Full product accumulator
  data_t                         lo_prod;

  assign hi_op     = (m_if.op == MUL_HS) | (m_if.op == MUL_HU);
  assign hi_start  = m_if.en & hi_op & (state_q == MULT_IDLE);
  assign op_signed = (m_if.op == MUL_HS);

  // Low word in a single cycle
  assign lo_prod = m_if.op_a * m_if.op_b;

  //////////////////////////////////////////////////////////////////////
  // High word partial products
  //////////////////////////////////////////////////////////////////////

  assign op_a_ext = {op_signed & m_if.op_a[XLEN-1], m_if.op_a};
  assign op_b_ext = {op_signed & m_if.op_b[XLEN-1], m_if.op_b};

  // Low half of B is always unsigned, upper 17 bits carry the sign
  assign pp_b = (state_q == MULT_STEP1) ? op_b_ext[XLEN:XLEN/2]
                                        : {1'b0, op_b_ext[XLEN/2-1:0]};

  assign pp     = op_a_ext * pp_b;
  assign pp_ext = {{(XLEN/2-2){pp[XLEN+XLEN/2+1]}}, pp};  // Sign extend to 64

  // Product accumulator over the two steps
  always_ff @(posedge clk) begin
    if (hi_start) begin
      acc_q <= pp_ext;                          // A * B[15:0]
    end else if (state_q == MULT_STEP1) begin
      acc_q <= acc_q + (pp_ext << (XLEN/2));    // + A * B[32:16] << 16
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    m_if.ready      = 1'b1;
    m_if.multicycle = 1'b0;

    case (state_q)
      MULT_IDLE: begin
        if (hi_start) begin
          state_d         = MULT_STEP1;
          m_if.ready      = 1'b0;
          m_if.multicycle = 1'b1;  // Cycle 1 of 3
        end
      end

      MULT_STEP1: begin
        state_d         = MULT_DONE;
        m_if.ready      = 1'b0;
        m_if.multicycle = 1'b1;    // Cycle 2 of 3
      end

      MULT_DONE: begin
        // Hold the high word until EX takes it
        if (m_if.ex_ready) begin
          state_d = MULT_IDLE;
        end
      end

      default: begin
        state_d = MULT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // High word only valid in DONE
  assign m_if.result = (state_q == MULT_DONE) ? acc_q[2*XLEN-1:XLEN] : lo_prod;

endmodule

`default_nettype wire

//--- rtl/ex_wb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ex_wb_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  ex_mult_if.ctrl          m_if,

  input  logic             alu_en_i,
  input  logic             csr_access_i,
  input  logic             lsu_en_i,
  input  logic             lsu_ready_ex_i,  // EX part of LSU done
  input  logic             branch_in_ex_i,
  input  logic             wb_ready_i,
  input  logic             regfile_alu_we_i,
  input  logic             regfile_we_i,

  input  ex_pkg::data_t    alu_result_i,
  input  ex_pkg::data_t    csr_rdata_i,
  input  ex_pkg::data_t    lsu_rdata_i,

  input  ex_pkg::rf_addr_t regfile_alu_waddr_i,
  input  ex_pkg::rf_addr_t regfile_waddr_i,

  // Forwarding port toward ID and RF
  output logic             regfile_alu_we_fw_o,
  output ex_pkg::rf_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::data_t    regfile_alu_wdata_fw_o,

  // Load write port
  output logic             regfile_we_wb_o,
  output ex_pkg::rf_addr_t regfile_waddr_wb_o,
  output ex_pkg::data_t    regfile_wdata_wb_o,

  output logic             ex_ready_o,
  output logic             ex_valid_o
);
  import ex_pkg::*;

  logic     regfile_we_lsu;
  rf_addr_t regfile_waddr_lsu;

  //////////////////////////////////////////////////////////////////////
  // ALU write port mux
  //////////////////////////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR wins over multiplier, multiplier over ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (m_if.en) begin
      regfile_alu_wdata_fw_o = m_if.result;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // EX/WB pipeline register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_lsu <= 1'b0;
    end else if (ex_valid_o) begin
      regfile_we_lsu <= regfile_we_i;
    end else if (wb_ready_i) begin
      regfile_we_lsu <= 1'b0;  // WB drained with nothing behind it
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && regfile_we_i) begin
      regfile_waddr_lsu <= regfile_waddr_i;
    end
  end

  assign regfile_we_wb_o    = regfile_we_lsu;
  assign regfile_waddr_wb_o = regfile_waddr_lsu;
  assign regfile_wdata_wb_o = lsu_rdata_i;  // Load data arrives in WB

  // Stall control
  // Branches resolve in EX so they never wait on WB
  assign ex_ready_o = (m_if.ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | m_if.en | csr_access_i | lsu_en_i)
                      & m_if.ready & lsu_ready_ex_i & wb_ready_i;

  assign m_if.ex_ready = ex_ready_o;  // Lets the multiplier retire

endmodule

`default_nettype wire

//--- rtl/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  logic             clk,
  input  logic             rst_n,

  // ALU operands from ID
  input  logic             alu_en_i,
  input  ex_pkg::alu_op_e  alu_operator_i,
  input  ex_pkg::data_t    alu_operand_a_i,
  input  ex_pkg::data_t    alu_operand_b_i,
  input  ex_pkg::data_t    alu_operand_c_i,  // Jump target

  // Multiplier
  input  logic             mult_en_i,
  input  ex_pkg::mult_op_e mult_operator_i,
  input  ex_pkg::data_t    mult_operand_a_i,
  input  ex_pkg::data_t    mult_operand_b_i,

  input  logic             csr_access_i,
  input  ex_pkg::data_t    csr_rdata_i,

  input  logic             lsu_en_i,
  input  ex_pkg::data_t    lsu_rdata_i,
  input  logic             lsu_ready_ex_i,

  input  logic             regfile_alu_we_i,
  input  ex_pkg::rf_addr_t regfile_alu_waddr_i,
  input  logic             regfile_we_i,      // Passed through to WB
  input  ex_pkg::rf_addr_t regfile_waddr_i,

  input  logic             branch_in_ex_i,
  input  logic             wb_ready_i,

  output logic             regfile_alu_we_fw_o,
  output ex_pkg::rf_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::data_t    regfile_alu_wdata_fw_o,

  output logic             regfile_we_wb_o,
  output ex_pkg::rf_addr_t regfile_waddr_wb_o,
  output ex_pkg::data_t    regfile_wdata_wb_o,

  output ex_pkg::data_t    jump_target_o,
  output logic             branch_decision_o,

  output logic             mult_multicycle_o,
  output logic             ex_ready_o,
  output logic             ex_valid_o
);
  import ex_pkg::*;

  data_t alu_result;
  logic  alu_cmp_result;

  ex_mult_if m_if ();

  assign m_if.en           = mult_en_i;
  assign m_if.op           = mult_operator_i;
  assign m_if.op_a         = mult_operand_a_i;
  assign m_if.op_b         = mult_operand_b_i;
  assign mult_multicycle_o = m_if.multicycle;

  // Branch handling
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  ex_alu alu_i (
    .operator_i   ( alu_operator_i  ),
    .operand_a_i  ( alu_operand_a_i ),
    .operand_b_i  ( alu_operand_b_i ),
    .result_o     ( alu_result      ),
    .cmp_result_o ( alu_cmp_result  )
  );

  ex_mult mult_i (
    .clk   ( clk   ),
    .rst_n ( rst_n ),
    .m_if  ( m_if  )
  );

  ex_wb_ctrl wb_ctrl_i (
    .clk                    ( clk                    ),
    .rst_n                  ( rst_n                  ),
    .m_if                   ( m_if                   ),
    .alu_en_i               ( alu_en_i               ),
    .csr_access_i           ( csr_access_i           ),
    .lsu_en_i               ( lsu_en_i               ),
    .lsu_ready_ex_i         ( lsu_ready_ex_i         ),
    .branch_in_ex_i         ( branch_in_ex_i         ),
    .wb_ready_i             ( wb_ready_i             ),
    .regfile_alu_we_i       ( regfile_alu_we_i       ),
    .regfile_we_i           ( regfile_we_i           ),
    .alu_result_i           ( alu_result             ),
    .csr_rdata_i            ( csr_rdata_i            ),
    .lsu_rdata_i            ( lsu_rdata_i            ),
    .regfile_alu_waddr_i    ( regfile_alu_waddr_i    ),
    .regfile_waddr_i        ( regfile_waddr_i        ),
    .regfile_alu_we_fw_o    ( regfile_alu_we_fw_o    ),
    .regfile_alu_waddr_fw_o ( regfile_alu_waddr_fw_o ),
    .regfile_alu_wdata_fw_o ( regfile_alu_wdata_fw_o ),
    .regfile_we_wb_o        ( regfile_we_wb_o        ),
    .regfile_waddr_wb_o     ( regfile_waddr_wb_o     ),
    .regfile_wdata_wb_o     ( regfile_wdata_wb_o     ),
    .ex_ready_o             ( ex_ready_o             ),
    .ex_valid_o             ( ex_valid_o             )
  );

endmodule

`default_nettype wire

//--- tb/ex_stage_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_asserts (
  input logic          clk,
  input logic          rst_n,
  input logic          wb_ready_i,
  input logic          ex_ready_i,
  input logic          we_wb_i,
  input logic          mult_en_i,
  input ex_pkg::data_t mult_result_i,
  input logic          mult_ready_i
);
  int unsigned fail_count = 0;

  // EX/WB register frozen while WB is blocked
  wb_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(we_wb_i))
    else begin
      $error("regfile_we_wb_o changed while wb_ready_i low");
      fail_count++;
    end

  // Final product held until EX takes it
  result_held: assert property (@(posedge clk) disable iff (!rst_n)
    mult_en_i && mult_ready_i && !ex_ready_i |=> $stable(mult_result_i))
    else begin
      $error("multiplier result changed before EX accepted it");
      fail_count++;
    end

  we_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !we_wb_i)
    else begin
      $error("regfile_we_wb_o active right after reset");
      fail_count++;
    end

  // High multiply holds ready low for exactly two cycles
  hi_busy_two: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(mult_ready_i) |=> !mult_ready_i ##1 mult_ready_i)
    else begin
      $error("high multiply busy phase not two cycles");
      fail_count++;
    end

endmodule

bind ex_wb_ctrl ex_stage_asserts asserts_i (
  .clk           ( clk             ),
  .rst_n         ( rst_n           ),
  .wb_ready_i    ( wb_ready_i      ),
  .ex_ready_i    ( ex_ready_o      ),
  .we_wb_i       ( regfile_we_wb_o ),
  .mult_en_i     ( m_if.en         ),
  .mult_result_i ( m_if.result     ),
  .mult_ready_i  ( m_if.ready      )
);

`default_nettype wire

//--- tb/tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
  import ex_pkg::*;

  localparam int unsigned N_OPS      = 300;
  localparam int unsigned RST_CYCLES = 10;
  localparam logic [31:0] LFSR_SEED  = 32'd11;
  // Worst op is a high multiply with three stall cycles
  localparam int unsigned MAX_CYCLES = 3 * (N_OPS * MULT_HI_CYCLES) + RST_CYCLES;

  logic     clk, rst_n;
  logic     alu_en_i, mult_en_i, csr_access_i, lsu_en_i, lsu_ready_ex_i;
  logic     regfile_alu_we_i, regfile_we_i, branch_in_ex_i, wb_ready_i;
  alu_op_e  alu_operator_i;
  mult_op_e mult_operator_i;
  data_t    alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  data_t    mult_operand_a_i, mult_operand_b_i, csr_rdata_i, lsu_rdata_i;
  rf_addr_t regfile_alu_waddr_i, regfile_waddr_i;
  logic     regfile_alu_we_fw_o, regfile_we_wb_o, branch_decision_o;
  logic     mult_multicycle_o, ex_ready_o, ex_valid_o;
  rf_addr_t regfile_alu_waddr_fw_o, regfile_waddr_wb_o;
  data_t    regfile_alu_wdata_fw_o, regfile_wdata_wb_o, jump_target_o;

  logic [31:0] lfsr;
  data_t       exp_data;      // Expected forwarding data
  logic        exp_valid, exp_ready, exp_multi, exp_branch;
  logic        chk_data, chk_branch;
  logic        wb_we_exp;     // EX/WB register model
  rf_addr_t    wb_waddr_exp;
  int unsigned errors, checks, cycles, asrt_fails;

  ex_stage ex_stage_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////////////////////////

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int unsigned n, output logic [31:0] v);
    int unsigned i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);  // One step per bit
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // Arithmetic, logic and shift results
  function automatic data_t ref_alu(input alu_op_e op, input data_t a, input data_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[SHAMT_W-1:0];
      ALU_SRL:  return a >> b[SHAMT_W-1:0];
      ALU_SRA:  return $unsigned($signed(a) >>> b[SHAMT_W-1:0]);
      ALU_SLT:  return data_t'($signed(a) < $signed(b));
      default:  return data_t'(a < b);  // SLTU
    endcase
  endfunction

  function automatic logic ref_branch(input alu_op_e op, input data_t a, input data_t b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return $signed(a) < $signed(b);
      ALU_GE:  return $signed(a) >= $signed(b);
      ALU_LTU: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Full 64-bit products with the word picked by opcode
  function automatic data_t ref_mult(input mult_op_e op, input data_t a, input data_t b);
    logic [2*XLEN-1:0] prod_s;
    logic [2*XLEN-1:0] prod_u;
    prod_s = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
    prod_u = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    case (op)
      MUL_HS:  return prod_s[2*XLEN-1:XLEN];
      MUL_HU:  return prod_u[2*XLEN-1:XLEN];
      default: return prod_u[XLEN-1:0];
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    errors++;
    $display("Fail at %0t: %s", $time, msg);
  endtask

  // Expectation for the next rising edge, then on to the next falling edge
  task automatic expect_cycle(input logic valid, input logic ready, input logic multi,
                              input logic dchk);
    exp_valid = valid;
    exp_ready = ready;
    exp_multi = multi;
    chk_data  = dchk;
    @(negedge clk);
  endtask

  task automatic set_idle();
    alu_en_i         = 1'b0;
    mult_en_i        = 1'b0;
    csr_access_i     = 1'b0;
    lsu_en_i         = 1'b0;
    branch_in_ex_i   = 1'b0;
    regfile_alu_we_i = 1'b0;
    regfile_we_i     = 1'b0;
    chk_branch       = 1'b0;
  endtask

  task automatic drive_op();
    logic [31:0] r;
    logic [31:0] w;
    data_t       a;
    data_t       b;
    logic        hi;
    logic        dchk;
    int unsigned stall;
    take_bits(16, r);
    take_bits(32, a);
    take_bits(32, b);
    if (r[12:11] == 2'b11) begin
      b = a;  // Equal operands now and then
    end
    alu_en_i            = (r[1:0] == 2'd0) | ((r[1:0] == 2'd1) & r[10]);
    csr_access_i        = (r[1:0] == 2'd1);
    mult_en_i           = (r[1:0] == 2'd2);
    lsu_en_i            = (r[1:0] == 2'd3);  // Load alone
    alu_operator_i      = alu_op_e'(r[5:2]);
    mult_operator_i     = r[7] ? MUL_HU : (r[6] ? MUL_HS : MUL_LO);
    alu_operand_a_i     = a;
    alu_operand_b_i     = b;
    mult_operand_a_i    = a;
    mult_operand_b_i    = b;
    regfile_alu_we_i    = r[13];
    regfile_we_i        = r[14];
    take_bits(12, w);
    regfile_alu_waddr_i = w[5:0];
    regfile_waddr_i     = w[11:6];
    take_bits(32, w);
    alu_operand_c_i     = w;
    take_bits(32, w);
    csr_rdata_i         = w;
    take_bits(32, w);
    lsu_rdata_i         = w;

    hi             = mult_en_i && (mult_operator_i != MUL_LO);
    chk_branch     = alu_en_i && !csr_access_i && (alu_operator_i >= ALU_EQ);
    branch_in_ex_i = chk_branch;
    exp_branch     = ref_branch(alu_operator_i, a, b);
    dchk           = csr_access_i | mult_en_i | (alu_en_i & ~chk_branch);
    if (csr_access_i) begin
      exp_data = csr_rdata_i;  // Overrides any ALU result
    end else if (mult_en_i) begin
      exp_data = ref_mult(mult_operator_i, a, b);
    end else begin
      exp_data = ref_alu(alu_operator_i, a, b);
    end

    stall          = r[9] ? (r[8] ? 3 : 1) : 0;  // WB or LSU back-pressure
    wb_ready_i     = 1'b1;
    lsu_ready_ex_i = 1'b1;
    if (hi) begin
      repeat (MULT_HI_CYCLES - 1) expect_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    end
    if (stall != 0) begin
      wb_ready_i     = r[15];   // One of the two holds EX
      lsu_ready_ex_i = ~r[15];
      repeat (stall) expect_cycle(1'b0, branch_in_ex_i, 1'b0, dchk);
      wb_ready_i     = 1'b1;
      lsu_ready_ex_i = 1'b1;
    end
    expect_cycle(1'b1, 1'b1, 1'b0, dchk);  // Accepted here
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      checks++;
      assert (ex_valid_o === exp_valid && ex_ready_o === exp_ready)
        else report_mismatch($sformatf("ex_valid_o/ex_ready_o %b/%b, expected %b/%b",
                                       ex_valid_o, ex_ready_o, exp_valid, exp_ready));
      assert (mult_multicycle_o === exp_multi)
        else report_mismatch($sformatf("mult_multicycle_o %b, expected %b",
                                       mult_multicycle_o, exp_multi));
      if (chk_data) begin
        assert (regfile_alu_wdata_fw_o === exp_data)
          else report_mismatch($sformatf("forwarded data %h, expected %h",
                                         regfile_alu_wdata_fw_o, exp_data));
        assert (regfile_alu_we_fw_o === regfile_alu_we_i &&
                regfile_alu_waddr_fw_o === regfile_alu_waddr_i)
          else report_mismatch("forwarding we or waddr differs from its input");
      end
      if (chk_branch) begin
        assert (branch_decision_o === exp_branch && jump_target_o === alu_operand_c_i)
          else report_mismatch($sformatf("branch %b target %h, expected %b target %h",
                                         branch_decision_o, jump_target_o,
                                         exp_branch, alu_operand_c_i));
      end
      assert (regfile_we_wb_o === wb_we_exp)
        else report_mismatch($sformatf("regfile_we_wb_o %b, expected %b",
                                       regfile_we_wb_o, wb_we_exp));
      if (wb_we_exp) begin
        assert (regfile_waddr_wb_o === wb_waddr_exp && regfile_wdata_wb_o === lsu_rdata_i)
          else report_mismatch($sformatf("WB addr %h data %h, expected %h %h",
                                         regfile_waddr_wb_o, regfile_wdata_wb_o,
                                         wb_waddr_exp, lsu_rdata_i));
      end
      // Register loads on valid, drains when WB ready with nothing valid
      if (exp_valid) begin
        wb_we_exp = regfile_we_i;
        if (regfile_we_i) begin
          wb_waddr_exp = regfile_waddr_i;
        end
      end else if (wb_ready_i) begin
        wb_we_exp = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    lfsr                = LFSR_SEED;
    errors              = 0;
    checks              = 0;
    cycles              = 0;
    rst_n               = 1'b0;
    set_idle();
    alu_operator_i      = ALU_ADD;
    mult_operator_i     = MUL_LO;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    csr_rdata_i         = '0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    wb_ready_i          = 1'b1;
    regfile_alu_waddr_i = '0;
    regfile_waddr_i     = '0;
    exp_data            = '0;
    exp_valid           = 1'b0;
    exp_ready           = 1'b1;
    exp_multi           = 1'b0;
    exp_branch          = 1'b0;
    chk_data            = 1'b0;
    wb_we_exp           = 1'b0;
    wb_waddr_exp        = '0;

    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    repeat (N_OPS) drive_op();
    set_idle();
    repeat (2) expect_cycle(1'b0, 1'b1, 1'b0, 1'b0);  // Drain WB

    asrt_fails = ex_stage_i.wb_ctrl_i.asserts_i.fail_count;
    $display("Summary: %0d cycles checked, %0d value errors, %0d assertion errors",
             checks, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ex_stage.f
common/ex_pkg.sv
common/ex_mult_if.sv
rtl/ex_alu.sv
mult/ex_mult.sv
rtl/ex_wb_ctrl.sv
rtl/ex_stage.sv
tb/ex_stage_asserts.sv
tb/tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  # Design, in compile order
  - common/ex_pkg.sv
  - common/ex_mult_if.sv
  - rtl/ex_alu.sv
  - mult/ex_mult.sv
  - rtl/ex_wb_ctrl.sv
  - rtl/ex_stage.sv

  # Testbench
  - target: test
    files:
      - tb/ex_stage_asserts.sv
      - tb/tb_ex_stage.sv
